/* tests/sd_stimulus.txt */
// One test per line, 32-bit hex words:
// low0 low1 high0 high1 off0 off1 pat0 pat1 exp0 exp1 faults combined
// Main ratio 16, comparator ratio 8, channel 1 inverted
// Test 0: ch0 k=14 gives 12-2, cmp 6 above 5; ch1 k=4 gives -(-8+3), cmp 4 in range
fffffff6 fffffffc 00000005 0000000a 00000002 fffffffd 0000fefe 00001111 0000000a 00000005 00000001 00000001
// Test 1: ch0 all zero gives -16, cmp -8 below -7; ch1 k=8 gives -(0-7), cmp 0 below 1
fffffff9 00000001 00000014 00000009 00000000 00000007 00000000 0000f0f0 0000fff0 00000007 00000003 00000001
// Test 2: ch0 k=8 gives 0+1, cmp 0 in range; ch1 all ones gives -(16-4), cmp -8 on the limit
00000000 fffffff8 00000000 00000000 ffffffff 00000004 0000aaaa 0000ffff 00000001 0000fff4 00000000 00000000

/* list.f */
rtl/sd_pkg.sv
rtl/sample_if.sv
rtl/sd_clock_gen.sv
rtl/sd_channel.sv
rtl/sd_fault_comparator.sv
rtl/sd_output_arbiter.sv
rtl/sd_config_regs.sv
rtl/sd_processor.sv
tests/sd_processor_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f list.f --top-module sd_processor_tb -o sd_sim > build.log 2>&1 \
    && ./obj_dir/sd_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or run error"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

/* tests/sd_processor_tb.sv */
`timescale 1ns/1ps

module sd_processor_tb import sd_pkg::*; ();

    localparam int N_CHANNELS = 2;
    localparam int MAIN_RATIO_LOG2 = 4;
    localparam int CMP_RATIO_LOG2 = 3;
    localparam int CLK_DIV_LOG2 = 2;
    localparam logic [N_CHANNELS-1:0] INVERT_SIGN = 2'b10;
    localparam real CLK_PERIOD = 8.0;
    localparam int N_TESTS = 3;
    // Words per test line in the data file
    localparam int WORDS = 12;
    // Modulator clock half period in system clocks
    localparam int SD_HALF = 2 ** (CLK_DIV_LOG2 - 1);
    // One main output period in ns
    localparam real DEC_PERIOD = CLK_PERIOD * (2 ** MAIN_RATIO_LOG2) * (2 ** CLK_DIV_LOG2);
    localparam real WATCHDOG_NS = N_TESTS * 40 * DEC_PERIOD;

    logic clock = 1'b0;
    logic rst;
    logic enable;
    logic sync;
    logic [N_CHANNELS-1:0] data_in;
    logic reg_we;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [REG_W-1:0] reg_wdata;
    logic [REG_W-1:0] reg_rdata;
    logic out_req;
    sample_t out_data;
    logic [CHAN_ID_W-1:0] out_chan;
    logic out_ack;
    logic sd_clk;
    logic [N_CHANNELS-1:0] channel_faults;
    logic combined_fault;

    logic [31:0] stim [N_TESTS * WORDS];
    logic [15:0] pat [N_CHANNELS];
    logic [3:0] bit_pos;
    logic [31:0] lfsr;
    sample_t got_q0 [$];
    sample_t got_q1 [$];
    int total_received;
    int value_errors;
    int proto_errors;

    sd_processor #(
        .N_CHANNELS(N_CHANNELS),
        .MAIN_RATIO_LOG2(MAIN_RATIO_LOG2),
        .CMP_RATIO_LOG2(CMP_RATIO_LOG2),
        .CLK_DIV_LOG2(CLK_DIV_LOG2),
        .INVERT_SIGN(INVERT_SIGN)
    ) dut_i (
        .clock(clock),
        .rst(rst),
        .enable(enable),
        .sync(sync),
        .data_in(data_in),
        .reg_we(reg_we),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .out_req(out_req),
        .out_data(out_data),
        .out_chan(out_chan),
        .out_ack(out_ack),
        .sd_clk(sd_clk),
        .channel_faults(channel_faults),
        .combined_fault(combined_fault)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Three bits taken with one step each
    task automatic ack_delay(output int dly);
        dly = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_next(lfsr);
            dly = (dly << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        assert (got === exp) else begin
            value_errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic write_reg(input int addr, input logic [31:0] val);
        @(negedge clock);
        reg_we = 1'b1;
        reg_addr = REG_ADDR_W'(addr);
        reg_wdata = val;
        @(negedge clock);
        reg_we = 1'b0;
    endtask

    // Read data is registered one clock after the address
    task automatic read_reg(input int addr, output logic [31:0] val);
        @(negedge clock);
        reg_addr = REG_ADDR_W'(addr);
        @(negedge clock);
        val = reg_rdata;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bitstream source and output sink
    //////////////////////////////////////////////////////////////////////

    // Next bit goes out on the falling edge after each sd_clk rise
    always begin
        @(posedge sd_clk);
        @(negedge clock);
        data_in = {pat[1][bit_pos], pat[0][bit_pos]};
        bit_pos = bit_pos - 1'b1;
    end

    // Sink with random ack delay that also checks tag alternation
    initial begin : sink
        int dly;
        int last_chan;
        last_chan = -1;
        forever begin
            @(posedge clock);
            if (out_req && !out_ack && !rst) begin
                ack_delay(dly);
                repeat (dly) @(posedge clock);
                @(negedge clock);
                out_ack = 1'b1;
                assert (out_chan < CHAN_ID_W'(N_CHANNELS)) else begin
                    value_errors++;
                    $display("ERR %0t out_chan expected below %0d got %0d",
                             $time, N_CHANNELS, out_chan);
                end
                assert (int'(out_chan) != last_chan) else begin
                    proto_errors++;
                    $display("Channel %0d served twice in a row at %0t", out_chan, $time);
                end
                last_chan = int'(out_chan);
                if (out_chan == 0) begin
                    got_q0.push_back(out_data);
                end else begin
                    got_q1.push_back(out_data);
                end
                total_received++;
                while (out_req) @(posedge clock);
                @(negedge clock);
                out_ack = 1'b0;
            end
        end
    end

    // Four-phase monitor on the output port
    initial begin : monitor
        logic prev_req;
        logic prev_ack;
        logic seen_ack;
        prev_req = 1'b0;
        prev_ack = 1'b0;
        seen_ack = 1'b0;
        forever begin
            @(posedge clock);
            if (!rst) begin
                if (!prev_req && out_req) begin
                    seen_ack = 1'b0;
                end
                if (out_req && out_ack) begin
                    seen_ack = 1'b1;
                end
                assert (!(prev_req && !out_req) || seen_ack) else begin
                    proto_errors++;
                    $display("out_req fell before out_ack rose at %0t", $time);
                end
                assert (!(prev_ack && !out_ack) || !out_req) else begin
                    proto_errors++;
                    $display("out_req high right after out_ack fell at %0t", $time);
                end
            end
            prev_req = out_req;
            prev_ack = out_ack;
        end
    end

    // Modulator clock level run length, restarted after reset or a pause
    initial begin : sd_clk_check
        int run;
        logic armed;
        logic prev_sd;
        run = 0;
        armed = 1'b0;
        prev_sd = 1'b0;
        forever begin
            @(posedge clock);
            if (rst || !enable) begin
                run = 0;
                armed = 1'b0;
            end else if (sd_clk !== prev_sd) begin
                if (armed) begin
                    assert (run == SD_HALF) else begin
                        value_errors++;
                        $display("ERR %0t sd_clk half period expected %0d got %0d",
                                 $time, SD_HALF, run);
                    end
                end
                armed = 1'b1;
                run = 1;
            end else begin
                run++;
            end
            prev_sd = sd_clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequences
    //////////////////////////////////////////////////////////////////////

    task automatic register_test();
        logic [31:0] val;
        int addrs [6];
        addrs = '{REG_LOW_BASE, REG_LOW_BASE + 1, REG_HIGH_BASE, REG_HIGH_BASE + 1,
                  REG_OFFSET_BASE, REG_OFFSET_BASE + 1};
        for (int i = 0; i < 6; i++) begin
            write_reg(addrs[i], 32'h5a00_1000 + 32'(i * 32'h0101_0111));
        end
        // Unmapped write must not land anywhere
        write_reg(5, 32'hdead_beef);
        for (int i = 0; i < 6; i++) begin
            read_reg(addrs[i], val);
            compare_word("reg_rdata", 32'h5a00_1000 + 32'(i * 32'h0101_0111), val);
        end
        read_reg(5, val);
        compare_word("reg_rdata unmapped", 32'h0, val);
        read_reg(8'h40, val);
        compare_word("reg_rdata unmapped", 32'h0, val);
    endtask

    task automatic run_test(input int t);
        int base;
        base = t * WORDS;
        write_reg(REG_LOW_BASE, stim[base]);
        write_reg(REG_LOW_BASE + 1, stim[base + 1]);
        write_reg(REG_HIGH_BASE, stim[base + 2]);
        write_reg(REG_HIGH_BASE + 1, stim[base + 3]);
        write_reg(REG_OFFSET_BASE, stim[base + 4]);
        write_reg(REG_OFFSET_BASE + 1, stim[base + 5]);
        pat[0] = stim[base + 6][15:0];
        pat[1] = stim[base + 7][15:0];
        @(negedge clock);
        sync = 1'b1;
        // Sink pushes on falling edges only
        @(posedge clock);
        got_q0.delete();
        got_q1.delete();
        @(negedge clock);
        sync = 1'b0;
        // Skip a stale sample and two settling ones
        while (got_q0.size() < 5 || got_q1.size() < 5) @(posedge clock);
        for (int i = 3; i < 5; i++) begin
            compare_word("out_data ch0", stim[base + 8], 32'(unsigned'(got_q0[i])));
            compare_word("out_data ch1", stim[base + 9], 32'(unsigned'(got_q1[i])));
        end
        compare_word("channel_faults", stim[base + 10], 32'(channel_faults));
        compare_word("combined_fault", stim[base + 11], 32'(combined_fault));
        // Widest window so every fault clears
        for (int c = 0; c < N_CHANNELS; c++) begin
            write_reg(REG_LOW_BASE + c, 32'hffff_8000);
            write_reg(REG_HIGH_BASE + c, 32'h0000_7fff);
        end
        repeat (4 * (2 ** CMP_RATIO_LOG2) * (2 ** CLK_DIV_LOG2)) @(negedge clock);
        compare_word("channel_faults", 32'h0, 32'(channel_faults));
        compare_word("combined_fault", 32'h0, 32'(combined_fault));
    endtask

    task automatic enable_test();
        int start;
        logic quiet;
        quiet = 1'b1;
        @(negedge clock);
        enable = 1'b0;
        // Let a sample already in flight drain
        repeat (64) @(negedge clock);
        repeat (8 * 64) begin
            @(posedge clock);
            if (out_req) begin
                quiet = 1'b0;
            end
        end
        assert (quiet) else begin
            proto_errors++;
            $display("out_req rose while enable was low");
        end
        start = total_received;
        @(negedge clock);
        enable = 1'b1;
        while (total_received < start + 2) @(posedge clock);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main flow and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        rst = 1'b1;
        enable = 1'b1;
        sync = 1'b0;
        data_in = '0;
        reg_we = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        out_ack = 1'b0;
        pat[0] = 16'h0;
        pat[1] = 16'h0;
        bit_pos = 4'hf;
        lfsr = 32'hd984_5bf3;
        total_received = 0;
        value_errors = 0;
        proto_errors = 0;
        $readmemh("tests/sd_stimulus.txt", stim);
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        register_test();
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        enable_test();
        $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not complete in time");
        $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* rtl/sd_processor.sv */
`timescale 1ns/1ps

module sd_processor import sd_pkg::*; #(
    parameter int N_CHANNELS = 2,
    parameter int MAIN_RATIO_LOG2 = 4,
    parameter int CMP_RATIO_LOG2 = 3,
    parameter int CLK_DIV_LOG2 = 2,
    parameter logic [N_CHANNELS-1:0] INVERT_SIGN = '0
) (
    input  logic clock,
    input  logic rst,
    input  logic enable,
    input  logic sync,
    input  logic [N_CHANNELS-1:0] data_in,
    input  logic reg_we,
    input  logic [REG_ADDR_W-1:0] reg_addr,
    input  logic [REG_W-1:0] reg_wdata,
    output logic [REG_W-1:0] reg_rdata,
    output logic out_req,
    output sample_t out_data,
    output logic [CHAN_ID_W-1:0] out_chan,
    input  logic out_ack,
    output logic sd_clk,
    output logic [N_CHANNELS-1:0] channel_faults,
    output logic combined_fault
);

    sample_t low_thr [N_CHANNELS];
    sample_t high_thr [N_CHANNELS];
    sample_t offsets [N_CHANNELS];
    sample_t cmp_data [N_CHANNELS];
    logic [N_CHANNELS-1:0] cmp_valid;
    logic bit_stb;
    logic main_stb;
    logic cmp_stb;

    //////////////////////////////////////////////////////////////////////
    // Control and timing
    //////////////////////////////////////////////////////////////////////

    sd_config_regs #(
        .N_CHANNELS(N_CHANNELS)
    ) regs_i (
        .clock(clock),
        .rst(rst),
        .reg_we(reg_we),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .low_thr(low_thr),
        .high_thr(high_thr),
        .offsets(offsets)
    );

    sd_clock_gen #(
        .CLK_DIV_LOG2(CLK_DIV_LOG2),
        .MAIN_RATIO_LOG2(MAIN_RATIO_LOG2),
        .CMP_RATIO_LOG2(CMP_RATIO_LOG2)
    ) clk_gen_i (
        .clock(clock),
        .rst(rst),
        .enable(enable),
        .sync(sync),
        .sd_clk(sd_clk),
        .bit_stb(bit_stb),
        .main_stb(main_stb),
        .cmp_stb(cmp_stb)
    );

    //////////////////////////////////////////////////////////////////////
    // Filters, two decimators per bitstream
    //////////////////////////////////////////////////////////////////////

    sample_if main_if [N_CHANNELS] ();
    // Comparator side needs no handshake
    sample_if cmp_if [N_CHANNELS] ();

    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_chan
        sd_channel #(
            .RATIO_LOG2(MAIN_RATIO_LOG2),
            .INVERT(INVERT_SIGN[i])
        ) main_i (
            .clock(clock),
            .rst(rst),
            .bit_in(data_in[i]),
            .bit_stb(bit_stb),
            .dec_stb(main_stb),
            .sync(sync),
            .offset(offsets[i]),
            .chan_id(CHAN_ID_W'(i)),
            .out(main_if[i]),
            .cmp_data(),
            .cmp_valid()
        );

        // No offset and no sync, raw range check only
        sd_channel #(
            .RATIO_LOG2(CMP_RATIO_LOG2),
            .INVERT(INVERT_SIGN[i])
        ) cmp_i (
            .clock(clock),
            .rst(rst),
            .bit_in(data_in[i]),
            .bit_stb(bit_stb),
            .dec_stb(cmp_stb),
            .sync(1'b0),
            .offset('0),
            .chan_id(CHAN_ID_W'(i)),
            .out(cmp_if[i]),
            .cmp_data(cmp_data[i]),
            .cmp_valid(cmp_valid[i])
        );

        assign cmp_if[i].ack = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Faults and shared output
    //////////////////////////////////////////////////////////////////////

    sd_fault_comparator #(
        .N_CHANNELS(N_CHANNELS)
    ) fault_i (
        .clock(clock),
        .rst(rst),
        .data(cmp_data),
        .valid(cmp_valid),
        .low_thr(low_thr),
        .high_thr(high_thr),
        .channel_faults(channel_faults),
        .combined_fault(combined_fault)
    );

    sd_output_arbiter #(
        .N_CHANNELS(N_CHANNELS)
    ) arb_i (
        .clock(clock),
        .rst(rst),
        .chans(main_if),
        .out_req(out_req),
        .out_data(out_data),
        .out_chan(out_chan),
        .out_ack(out_ack)
    );

endmodule

/* rtl/sd_config_regs.sv */
`timescale 1ns/1ps

module sd_config_regs import sd_pkg::*; #(
    parameter int N_CHANNELS = 2
) (
    input  logic clock,
    input  logic rst,
    input  logic reg_we,
    input  logic [REG_ADDR_W-1:0] reg_addr,
    input  logic [REG_W-1:0] reg_wdata,
    output logic [REG_W-1:0] reg_rdata,
    output sample_t low_thr [N_CHANNELS],
    output sample_t high_thr [N_CHANNELS],
    output sample_t offsets [N_CHANNELS]
);

    localparam int N_REGS = 3 * N_CHANNELS;
    localparam int IDX_W = $clog2(N_REGS);

    // Flat storage: low bank, then high bank, then offset bank
    logic [REG_W-1:0] regs [N_REGS];
    logic hit;
    logic [IDX_W-1:0] idx;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        hit = 1'b0;
        idx = '0;
        for (int c = 0; c < N_CHANNELS; c++) begin
            if (reg_addr == REG_ADDR_W'(REG_LOW_BASE + c)) begin
                hit = 1'b1;
                idx = IDX_W'(c);
            end
            if (reg_addr == REG_ADDR_W'(REG_HIGH_BASE + c)) begin
                hit = 1'b1;
                idx = IDX_W'(N_CHANNELS + c);
            end
            if (reg_addr == REG_ADDR_W'(REG_OFFSET_BASE + c)) begin
                hit = 1'b1;
                idx = IDX_W'(2 * N_CHANNELS + c);
            end
        end
    end

    // Unmapped writes dropped, unmapped reads give zero
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int r = 0; r < N_REGS; r++) begin
                regs[r] <= '0;
            end
            reg_rdata <= '0;
        end else begin
            if (reg_we && hit) begin
                regs[idx] <= reg_wdata;
            end
            reg_rdata <= hit ? regs[idx] : '0;
        end
    end

    // Only the low bits feed the datapath
    for (genvar c = 0; c < N_CHANNELS; c++) begin : g_out
        assign low_thr[c] = sample_t'(regs[c][SAMPLE_W-1:0]);
        assign high_thr[c] = sample_t'(regs[N_CHANNELS + c][SAMPLE_W-1:0]);
        assign offsets[c] = sample_t'(regs[2 * N_CHANNELS + c][SAMPLE_W-1:0]);
    end

endmodule

/* rtl/sd_output_arbiter.sv */
`timescale 1ns/1ps

module sd_output_arbiter import sd_pkg::*; #(
    parameter int N_CHANNELS = 2
) (
    input  logic clock,
    input  logic rst,
    sample_if.arbiter chans [N_CHANNELS],
    output logic out_req,
    output sample_t out_data,
    output logic [CHAN_ID_W-1:0] out_chan,
    input  logic out_ack
);

    localparam int IDX_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_OUT,
        S_CLOSE
    } state_t;

    state_t state;
    logic [N_CHANNELS-1:0] req_vec;
    logic [N_CHANNELS-1:0] ack_vec;
    sample_t data_arr [N_CHANNELS];
    logic [CHAN_ID_W-1:0] tag_arr [N_CHANNELS];
    logic [IDX_W-1:0] last;
    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] pick;
    logic found;

    // Flatten the interface array so it can be indexed at run time
    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_chan
        assign req_vec[i] = chans[i].req;
        assign data_arr[i] = chans[i].data;
        assign tag_arr[i] = chans[i].chan;
        assign chans[i].ack = ack_vec[i];
    end

    //////////////////////////////////////////////////////////////////////
    // Round-robin pick, search starts after the last grant
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        int cand;
        found = 1'b0;
        pick = last;
        for (int k = 1; k <= N_CHANNELS; k++) begin
            cand = (int'(last) + k) % N_CHANNELS;
            if (!found && req_vec[cand]) begin
                found = 1'b1;
                pick = IDX_W'(cand);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Both handshakes in lockstep
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= S_IDLE;
            out_req <= 1'b0;
            ack_vec <= '0;
            grant <= '0;
            // Channel 0 wins first
            last <= IDX_W'(N_CHANNELS - 1);
        end else begin
            case (state)
                S_IDLE: begin
                    if (found) begin
                        grant <= pick;
                        out_req <= 1'b1;
                        state <= S_OUT;
                    end
                end
                // Sink took the sample, pass the ack back to the channel
                S_OUT: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        ack_vec[grant] <= 1'b1;
                        state <= S_CLOSE;
                    end
                end
                // Grant held until both sides are back to zero
                S_CLOSE: begin
                    if (!req_vec[grant] && !out_ack) begin
                        ack_vec <= '0;
                        last <= grant;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Payload captured with the grant
    always_ff @(posedge clock) begin
        if (state == S_IDLE && found) begin
            out_data <= data_arr[pick];
            out_chan <= tag_arr[pick];
        end
    end

endmodule

/* rtl/sd_fault_comparator.sv */
`timescale 1ns/1ps

module sd_fault_comparator import sd_pkg::*; #(
    parameter int N_CHANNELS = 2
) (
    input  logic clock,
    input  logic rst,
    input  sample_t data [N_CHANNELS],
    input  logic [N_CHANNELS-1:0] valid,
    input  sample_t low_thr [N_CHANNELS],
    input  sample_t high_thr [N_CHANNELS],
    output logic [N_CHANNELS-1:0] channel_faults,
    output logic combined_fault
);

    logic [N_CHANNELS-1:0] out_of_range;

    // Signed window check per channel
    always_comb begin
        for (int i = 0; i < N_CHANNELS; i++) begin
            out_of_range[i] = (data[i] > high_thr[i]) || (data[i] < low_thr[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            channel_faults <= '0;
            combined_fault <= 1'b0;
        end else begin
            // Each fault holds until its next comparator sample
            for (int i = 0; i < N_CHANNELS; i++) begin
                if (valid[i]) begin
                    channel_faults[i] <= out_of_range[i];
                end
            end
            // Trails the per-channel faults by one clock
            combined_fault <= |channel_faults;
        end
    end

endmodule

/* rtl/sd_channel.sv */
`timescale 1ns/1ps

module sd_channel import sd_pkg::*; #(
    parameter int RATIO_LOG2 = 4,
    parameter bit INVERT = 1'b0
) (
    input  logic clock,
    input  logic rst,
    input  logic bit_in,
    input  logic bit_stb,
    input  logic dec_stb,
    input  logic sync,
    input  sample_t offset,
    input  logic [CHAN_ID_W-1:0] chan_id,
    sample_if.channel out,
    output sample_t cmp_data,
    output logic cmp_valid
);

    // One bit above the CIC growth so an all-ones window reaches +R
    localparam int W = cic_width(RATIO_LOG2) + 1;
    localparam int SH = cic_shift(RATIO_LOG2);
    // Headroom for offset subtraction and negation
    localparam int EXT_W = SAMPLE_W + 2;
    localparam sample_t SAT_MAX = sample_t'({1'b0, {(SAMPLE_W - 1){1'b1}}});
    localparam sample_t SAT_MIN = sample_t'({1'b1, {(SAMPLE_W - 1){1'b0}}});

    if (RATIO_LOG2 < MIN_RATIO_LOG2 || RATIO_LOG2 > MAX_RATIO_LOG2) begin : g_bad_ratio
        $fatal(1, "sd_channel: RATIO_LOG2 %0d out of range", RATIO_LOG2);
    end

    logic signed [W-1:0] step;
    logic signed [W-1:0] integ1, integ2, integ3;
    logic signed [W-1:0] sum1, sum2, sum3;
    logic signed [W-1:0] dly1, dly2, dly3;
    logic signed [W-1:0] comb1, comb2, comb3;
    logic signed [W-1:0] comb_q;
    logic signed [W-SH-1:0] decimated;
    logic signed [EXT_W-1:0] diff;
    logic signed [EXT_W-1:0] corrected;
    sample_t scaled;
    logic stb_d;
    logic launch;

    //////////////////////////////////////////////////////////////////////
    // Integrators step once per modulator bit
    //////////////////////////////////////////////////////////////////////

    // Bit 1 maps to +1, bit 0 to -1
    assign step = bit_in ? W'(1) : {W{1'b1}};

    always_comb begin
        sum1 = integ1 + step;
        sum2 = integ2 + sum1;
        sum3 = integ3 + sum2;
    end

    always_ff @(posedge clock) begin
        if (rst || sync) begin
            integ1 <= '0;
            integ2 <= '0;
            integ3 <= '0;
        end else if (bit_stb) begin
            // wraps freely and the combs undo it
            integ1 <= sum1;
            integ2 <= sum2;
            integ3 <= sum3;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Combs at the decimated rate
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        comb1 = integ3 - dly1;
        comb2 = comb1 - dly2;
        comb3 = comb2 - dly3;
    end

    always_ff @(posedge clock) begin
        if (rst || sync) begin
            dly1 <= '0;
            dly2 <= '0;
            dly3 <= '0;
            comb_q <= '0;
        end else if (dec_stb) begin
            dly1 <= integ3;
            dly2 <= comb1;
            dly3 <= comb2;
            comb_q <= comb3;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Scaling, offset, sign and saturation
    //////////////////////////////////////////////////////////////////////

    // Arithmetic shift right by 2*log2(R) leaves 2k-R
    assign decimated = comb_q[W-1:SH];

    always_comb begin
        diff = EXT_W'(decimated) - EXT_W'(offset);
        corrected = INVERT ? -diff : diff;
        if (corrected > EXT_W'(SAT_MAX)) begin
            scaled = SAT_MAX;
        end else if (corrected < EXT_W'(SAT_MIN)) begin
            scaled = SAT_MIN;
        end else begin
            scaled = sample_t'(corrected[SAMPLE_W-1:0]);
        end
    end

    // Sample lands one clock after the strobe that loaded comb_q
    always_ff @(posedge clock) begin
        if (rst) begin
            stb_d <= 1'b0;
            cmp_valid <= 1'b0;
        end else begin
            stb_d <= dec_stb;
            cmp_valid <= stb_d;
        end
    end

    always_ff @(posedge clock) begin
        if (stb_d) begin
            cmp_data <= scaled;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Four-phase output
    //////////////////////////////////////////////////////////////////////

    // Idle needs both req and ack low or the sample is dropped
    assign launch = cmp_valid && !out.req && !out.ack;
    assign out.chan = chan_id;

    always_ff @(posedge clock) begin
        if (rst) begin
            out.req <= 1'b0;
        end else if (out.req && out.ack) begin
            out.req <= 1'b0;
        end else if (launch) begin
            out.req <= 1'b1;
        end
    end

    // Held for the whole handshake
    always_ff @(posedge clock) begin
        if (launch) begin
            out.data <= cmp_data;
        end
    end

endmodule

/* rtl/sd_clock_gen.sv */
`timescale 1ns/1ps

module sd_clock_gen #(
    parameter int CLK_DIV_LOG2 = 2,
    parameter int MAIN_RATIO_LOG2 = 4,
    parameter int CMP_RATIO_LOG2 = 3
) (
    input  logic clock,
    input  logic rst,
    input  logic enable,
    input  logic sync,
    output logic sd_clk,
    output logic bit_stb,
    output logic main_stb,
    output logic cmp_stb
);

    // Last count before the divider MSB rises
    localparam logic [CLK_DIV_LOG2-1:0] RISE_CNT = CLK_DIV_LOG2'(2 ** (CLK_DIV_LOG2 - 1) - 1);

    logic [CLK_DIV_LOG2-1:0] div_cnt;
    logic [MAIN_RATIO_LOG2-1:0] main_cnt;
    logic [CMP_RATIO_LOG2-1:0] cmp_cnt;
    logic bit_tick;

    // Modulator clock is the divider MSB, low out of reset
    assign sd_clk = div_cnt[CLK_DIV_LOG2-1];

    // Next edge raises sd_clk
    assign bit_tick = enable && (div_cnt == RISE_CNT);

    always_ff @(posedge clock) begin
        if (rst) begin
            div_cnt <= '0;
            main_cnt <= '0;
            cmp_cnt <= '0;
            bit_stb <= 1'b0;
            main_stb <= 1'b0;
            cmp_stb <= 1'b0;
        end else begin
            // Strobes line up with the cycle where sd_clk is freshly high
            bit_stb <= bit_tick;
            main_stb <= bit_tick && (main_cnt == '1) && !sync;
            cmp_stb <= bit_tick && (cmp_cnt == '1);

            if (enable) begin
                div_cnt <= div_cnt + 1'b1;
            end

            // Main window restarts from sync
            if (sync) begin
                main_cnt <= '0;
            end else if (bit_tick) begin
                main_cnt <= main_cnt + 1'b1;
            end

            // Comparator window is free running
            if (bit_tick) begin
                cmp_cnt <= cmp_cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/sample_if.sv */
`timescale 1ns/1ps

interface sample_if import sd_pkg::*; ();

    // Four-phase handshake pair
    logic req;
    logic ack;

    // Payload, stable while req is high
    sample_t data;
    logic [CHAN_ID_W-1:0] chan;

    // Producer side, one per main channel
    modport channel (
        output req, data, chan,
        input  ack
    );

    // Consumer side, the output arbiter
    modport arbiter (
        input  req, data, chan,
        output ack
    );

endinterface

/* rtl/sd_pkg.sv */
package sd_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data widths
    //////////////////////////////////////////////////////////////////////

    // Signed output sample
    localparam int SAMPLE_W = 16;
    // Configuration register
    localparam int REG_W = 32;
    // Channel tag on the shared output port
    localparam int CHAN_ID_W = 4;
    // Register port address
    localparam int REG_ADDR_W = 8;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    // One slot per possible channel tag in each bank
    localparam int BANK_STRIDE = 2 ** CHAN_ID_W;
    localparam int REG_LOW_BASE = 0;
    localparam int REG_HIGH_BASE = BANK_STRIDE;
    localparam int REG_OFFSET_BASE = 2 * BANK_STRIDE;

    // Supported decimation ratios, as log2
    localparam int MIN_RATIO_LOG2 = 2;
    localparam int MAX_RATIO_LOG2 = 6;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // CIC3 register growth is 3*log2(R), plus one bit for the +/-1 input
    function automatic int cic_width(input int ratio_log2);
        return 3 * ratio_log2 + 1;
    endfunction

    // Drops the R^2 gain of the two upper stages
    function automatic int cic_shift(input int ratio_log2);
        return 2 * ratio_log2;
    endfunction

endpackage
